/* common/vrob_macros.svh */
/*
 * Sizing macros for the vector reorder buffer
 * Entry count, register width in bits and bytes, element index width
 */

`ifndef VROB_MACROS_SVH
`define VROB_MACROS_SVH

// Number of reorder buffer entries
`define VROB_ENTRIES 16

// One vector register
`define VREG_BITS    128
`define VREG_BYTES   16

// Element index within a group of up to 8 registers at SEW8
`define VIDX_BITS    7

`endif

/* common/vrob_pkg.sv */
/*
 * Shared types for the vector reorder buffer
 * SEW and LMUL encodings, vector typedefs,
 * writeback, placed write and commit structs
 */

package vrob_pkg;

  `include "vrob_macros.svh"

  typedef enum logic [1:0] {
    SEW8  = 2'b00,
    SEW16 = 2'b01,
    SEW32 = 2'b10
  } sew_e;

  // Fractional settings follow the vlmul encoding
  typedef enum logic [2:0] {
    LMUL1      = 3'b000,
    LMUL2      = 3'b001,
    LMUL4      = 3'b010,
    LMUL8      = 3'b011,
    LMULEIGHTH = 3'b101,
    LMULFOURTH = 3'b110,
    LMULHALF   = 3'b111
  } lmul_e;

  typedef logic [$clog2(`VROB_ENTRIES)-1:0] rob_idx_t;
  typedef logic [4:0]                       vreg_t;
  typedef logic [`VIDX_BITS-1:0]            elem_idx_t;
  typedef logic [7:0]                       vlen_t;
  typedef logic [`VREG_BITS-1:0]            vdata_t;
  typedef logic [`VREG_BYTES-1:0]           byte_en_t;

  // Two-element result from one pipeline, one element per 32-bit lane
  typedef struct packed {
    logic        ready;
    rob_idx_t    index;
    vreg_t       vd;
    elem_idx_t   woffset;
    vlen_t       vl;
    sew_e        sew;
    logic [63:0] wdata;
    logic [1:0]  wen;
  } wb_t;

  typedef struct packed {
    logic     write;
    rob_idx_t entry;
    vreg_t    vd;
    vdata_t   data;
    byte_en_t lanes;
    byte_en_t byte_ena;
    logic     complete;
  } placed_t;

  typedef struct packed {
    logic     vreg_wen;
    vreg_t    vd;
    byte_en_t byte_ena;
    vdata_t   wdata;
  } commit_t;

endpackage

/* rob/wb_packer.sv */
/*
 * Writeback packer
 * Places a two-element pipeline result into its entry, register
 * and byte lanes, and flags when the entry becomes complete
 */

`timescale 1ns/1ps

`include "vrob_macros.svh"

module wb_packer (
  input  vrob_pkg::wb_t     wb,
  output vrob_pkg::placed_t placed
);
  import vrob_pkg::*;

  localparam int PAD_BITS  = `VREG_BITS - 64;
  localparam int PAD_BYTES = `VREG_BYTES - 8;

  logic [2:0]  reg_off;
  logic [3:0]  byte_off;
  logic [63:0] pair_data;
  logic [7:0]  pair_lanes;
  logic [7:0]  pair_en;
  logic        reg_filled;
  logic        vl_end;
  vlen_t       woff_ext;

  //==================================================
  // Element geometry per SEW
  //==================================================
  // epr is 4, 8 or 16, so the divide and modulo are bit slices
  always_comb begin
    case (wb.sew)
      SEW32: begin
        reg_off    = wb.woffset[4:2];
        byte_off   = {wb.woffset[1:0], 2'b00};
        reg_filled = (wb.woffset[1:0] == 2'd2);
        pair_data  = wb.wdata;
        pair_lanes = 8'hff;
        pair_en    = {{4{wb.wen[1]}}, {4{wb.wen[0]}}};
      end
      SEW16: begin
        reg_off    = wb.woffset[5:3];
        byte_off   = {wb.woffset[2:0], 1'b0};
        reg_filled = (wb.woffset[2:0] == 3'd6);
        pair_data  = {32'd0, wb.wdata[47:32], wb.wdata[15:0]};
        pair_lanes = 8'h0f;
        pair_en    = {4'd0, {2{wb.wen[1]}}, {2{wb.wen[0]}}};
      end
      default: begin
        // SEW8
        reg_off    = wb.woffset[6:4];
        byte_off   = wb.woffset[3:0];
        reg_filled = (wb.woffset[3:0] == 4'd14);
        pair_data  = {48'd0, wb.wdata[39:32], wb.wdata[7:0]};
        pair_lanes = 8'h03;
        pair_en    = {6'd0, wb.wen};
      end
    endcase
  end

  // Last one or two elements of the vector
  assign woff_ext = vlen_t'(wb.woffset);
  assign vl_end   = (woff_ext == wb.vl - 8'd1) || (woff_ext == wb.vl - 8'd2);

  //==================================================
  // Placed write
  //==================================================
  assign placed.write    = wb.ready;
  // Entry index wraps around the buffer
  assign placed.entry    = wb.index + rob_idx_t'(reg_off);
  assign placed.vd       = wb.vd + vreg_t'(reg_off);
  assign placed.data     = {{PAD_BITS{1'b0}}, pair_data} << {byte_off, 3'b000};
  assign placed.lanes    = {{PAD_BYTES{1'b0}}, pair_lanes} << byte_off;
  assign placed.byte_ena = {{PAD_BYTES{1'b0}}, pair_en} << byte_off;
  assign placed.complete = reg_filled | vl_end;

endmodule

/* rob/rob_store.sv */
/*
 * Reorder buffer entry store
 * Head and tail pointers with wrap bits, entry array,
 * merge of the arithmetic and multiply writes, in-order commit
 */

`timescale 1ns/1ps

`include "vrob_macros.svh"

module rob_store (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              flush,
  input  logic              alloc_ena,
  input  vrob_pkg::lmul_e   lmul,
  input  vrob_pkg::placed_t arith_wr,
  input  vrob_pkg::placed_t mul_wr,
  input  logic              commit_ena,
  output vrob_pkg::rob_idx_t cur_tail,
  output logic              full,
  output vrob_pkg::commit_t commit
);
  import vrob_pkg::*;

  localparam int IDX_W = $clog2(`VROB_ENTRIES);

  typedef struct packed {
    logic     valid;
    vreg_t    vd;
    byte_en_t byte_ena;
    vdata_t   data;
  } entry_t;

  entry_t rob      [`VROB_ENTRIES];
  entry_t next_rob [`VROB_ENTRIES];

  // Extra MSB is the wrap bit
  logic [IDX_W:0] head;
  logic [IDX_W:0] tail;
  logic [IDX_W:0] next_head;
  logic [IDX_W:0] next_tail;
  logic [IDX_W:0] grp_size;
  rob_idx_t       head_idx;

  // Replace only the bytes a write covers
  function automatic entry_t merge_write(entry_t cur, placed_t wr);
    entry_t upd;
    vdata_t bit_mask;
    int     b;
    upd = cur;
    for (b = 0; b < `VREG_BYTES; b++) begin
      bit_mask[b*8 +: 8] = {8{wr.lanes[b]}};
    end
    upd.data     = (cur.data & ~bit_mask) | (wr.data & bit_mask);
    upd.byte_ena = (cur.byte_ena & ~wr.lanes) | (wr.byte_ena & wr.lanes);
    upd.vd       = wr.vd;
    upd.valid    = wr.complete;
    return upd;
  endfunction

  //==================================================
  // Head entry and status
  //==================================================
  assign head_idx = head[IDX_W-1:0];
  assign cur_tail = tail[IDX_W-1:0];
  assign full     = (head[IDX_W-1:0] == tail[IDX_W-1:0]) && (head[IDX_W] != tail[IDX_W]);

  assign commit.vreg_wen = rob[head_idx].valid & commit_ena;
  assign commit.vd       = rob[head_idx].vd;
  assign commit.byte_ena = rob[head_idx].byte_ena;
  assign commit.wdata    = rob[head_idx].data;

  //==================================================
  // Pointers
  //==================================================
  // Fractional LMUL still takes one register
  always_comb begin
    case (lmul)
      LMUL2:   grp_size = (IDX_W+1)'(2);
      LMUL4:   grp_size = (IDX_W+1)'(4);
      LMUL8:   grp_size = (IDX_W+1)'(8);
      default: grp_size = (IDX_W+1)'(1);
    endcase
  end

  always_comb begin
    next_head = head;
    next_tail = tail;
    if (flush) begin
      next_head = '0;
      next_tail = '0;
    end else begin
      if (commit.vreg_wen) begin
        next_head = head + 1'b1;
      end
      if (alloc_ena && !full) begin
        next_tail = tail + grp_size;
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      head <= '0;
      tail <= '0;
    end else begin
      head <= next_head;
      tail <= next_tail;
    end
  end

  //==================================================
  // Entry array
  //==================================================
  always_comb begin
    next_rob = rob;
    if (flush) begin
      for (int i = 0; i < `VROB_ENTRIES; i++) begin
        next_rob[i] = '0;
      end
    end else begin
      if (commit.vreg_wen) begin
        next_rob[head_idx] = '0;
      end
      // Multiply applied last so it wins vd and valid on a shared entry
      if (arith_wr.write) begin
        next_rob[arith_wr.entry] = merge_write(next_rob[arith_wr.entry], arith_wr);
      end
      if (mul_wr.write) begin
        next_rob[mul_wr.entry] = merge_write(next_rob[mul_wr.entry], mul_wr);
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `VROB_ENTRIES; i++) begin
        rob[i] <= '0;
      end
    end else begin
      rob <= next_rob;
    end
  end

endmodule

/* src/vrob_top.sv */
/*
 * Vector reorder buffer top level
 * Arithmetic and multiply writeback packers feeding the entry store
 */

`timescale 1ns/1ps

module vrob_top (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               flush,
  input  logic               alloc_ena,
  input  vrob_pkg::lmul_e    lmul,
  input  vrob_pkg::wb_t      arith_wb,
  input  vrob_pkg::wb_t      mul_wb,
  input  logic               commit_ena,
  output vrob_pkg::rob_idx_t cur_tail,
  output logic               full,
  output vrob_pkg::commit_t  commit
);
  import vrob_pkg::*;

  placed_t arith_wr;
  placed_t mul_wr;

  // One packer per execution pipeline
  wb_packer i_arith_packer (
    .wb     (arith_wb),
    .placed (arith_wr)
  );

  wb_packer i_mul_packer (
    .wb     (mul_wb),
    .placed (mul_wr)
  );

  rob_store i_rob_store (
    .CLK        (CLK),
    .nRST       (nRST),
    .flush      (flush),
    .alloc_ena  (alloc_ena),
    .lmul       (lmul),
    .arith_wr   (arith_wr),
    .mul_wr     (mul_wr),
    .commit_ena (commit_ena),
    .cur_tail   (cur_tail),
    .full       (full),
    .commit     (commit)
  );

endmodule

/* sim/tb_vrob.sv */
/*
 * Testbench for the vector reorder buffer
 * Clock and reset, LFSR, reference model, commit compare process,
 * directed tests and the closing summary
 */

`timescale 1ns/1ps

`include "vrob_macros.svh"

module tb_vrob;
  import vrob_pkg::*;

  logic      CLK;
  logic      nRST;
  logic      flush;
  logic      alloc_ena;
  lmul_e     lmul;
  wb_t       arith_wb;
  wb_t       mul_wb;
  logic      commit_ena;
  rob_idx_t  cur_tail;
  logic      full;
  commit_t   commit;

  // Reference entries and head pointer
  logic      exp_valid [`VROB_ENTRIES];
  vreg_t     exp_vd    [`VROB_ENTRIES];
  vdata_t    exp_data  [`VROB_ENTRIES];
  byte_en_t  exp_be    [`VROB_ENTRIES];
  int        mhead;
  byte_en_t  last_be;
  logic [15:0] lfsr;
  int        errors;
  int        commit_count;
  int        tests_run;
  int        tests_failed;

  vrob_top i_vrob_top (
    .CLK        (CLK),
    .nRST       (nRST),
    .flush      (flush),
    .alloc_ena  (alloc_ena),
    .lmul       (lmul),
    .arith_wb   (arith_wb),
    .mul_wb     (mul_wb),
    .commit_ena (commit_ena),
    .cur_tail   (cur_tail),
    .full       (full),
    .commit     (commit)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  //==================================================
  // Random data, reference model and checks
  //==================================================
  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] val;
    logic        out_bit;
    val = '0;
    for (int i = 0; i < n; i++) begin
      out_bit = lfsr[0];
      lfsr = lfsr >> 1;
      if (out_bit) lfsr = lfsr ^ 16'hb400;
      val = {val[30:0], out_bit};
    end
    return val;
  endfunction

  // Applies one writeback to the reference entries
  function automatic void vrob_expect(wb_t w);
    int sew_bytes;
    int epr;
    int grp_reg;
    int pos;
    int ent;
    int p;
    logic [31:0] elem;
    case (w.sew)
      SEW32:   sew_bytes = 4;
      SEW16:   sew_bytes = 2;
      default: sew_bytes = 1;
    endcase
    epr     = `VREG_BYTES / sew_bytes;
    grp_reg = int'(w.woffset) / epr;
    pos     = int'(w.woffset) % epr;
    ent     = (int'(w.index) + grp_reg) % `VROB_ENTRIES;
    exp_vd[ent] = w.vd + vreg_t'(grp_reg);
    for (int e = 0; e < 2; e++) begin
      elem = w.wdata[e*32 +: 32];
      for (int k = 0; k < sew_bytes; k++) begin
        p = (pos + e) * sew_bytes + k;
        exp_data[ent][p*8 +: 8] = elem[k*8 +: 8];
        exp_be[ent][p] = w.wen[e];
      end
    end
    exp_valid[ent] = (pos + 2 == epr) || (int'(w.woffset) == int'(w.vl) - 1) ||
                     (int'(w.woffset) == int'(w.vl) - 2);
  endfunction

  function automatic wb_t make_wb(rob_idx_t index, vreg_t vd, int woff, int vl, sew_e sew,
                                  logic [1:0] wen);
    wb_t w;
    w.ready       = 1'b1;
    w.index       = index;
    w.vd          = vd;
    w.woffset     = elem_idx_t'(woff);
    w.vl          = vlen_t'(vl);
    w.sew         = sew;
    w.wdata[31:0] = rand_bits(32);
    w.wdata[63:32] = rand_bits(32);
    w.wen         = wen;
    return w;
  endfunction

  task automatic check_val(string name, logic [127:0] got, logic [127:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got %0h expected %0h", name, got, exp);
      errors++;
    end
  endtask

  // Every commit is compared against the reference head entry
  always @(negedge CLK) begin
    if (nRST && commit.vreg_wen) begin
      if (!exp_valid[mhead]) begin
        $display("Commit from entry %0d came before that entry was complete", mhead);
        errors++;
      end else begin
        check_val("commit.vd", 128'(commit.vd), 128'(exp_vd[mhead]));
        check_val("commit.byte_ena", 128'(commit.byte_ena), 128'(exp_be[mhead]));
        check_val("commit.wdata", commit.wdata, exp_data[mhead]);
      end
      last_be          = commit.byte_ena;
      exp_valid[mhead] = 1'b0;
      exp_data[mhead]  = '0;
      exp_be[mhead]    = '0;
      mhead            = (mhead + 1) % `VROB_ENTRIES;
      commit_count++;
    end
  end

  //==================================================
  // Stimulus tasks
  //==================================================
  task automatic send_wb(wb_t a, wb_t m);
    @(posedge CLK);
    arith_wb <= a;
    mul_wb   <= m;
    @(posedge CLK);
    arith_wb <= '0;
    mul_wb   <= '0;
    if (a.ready) vrob_expect(a);
    if (m.ready) vrob_expect(m);
  endtask

  task automatic alloc(lmul_e l, int exp_tail);
    @(posedge CLK);
    alloc_ena <= 1'b1;
    lmul      <= l;
    @(posedge CLK);
    alloc_ena <= 1'b0;
    @(negedge CLK);
    check_val("cur_tail", 128'(cur_tail), 128'(exp_tail));
  endtask

  task automatic do_flush();
    @(posedge CLK);
    flush <= 1'b1;
    @(posedge CLK);
    flush <= 1'b0;
    for (int i = 0; i < `VROB_ENTRIES; i++) begin
      exp_valid[i] = 1'b0;
      exp_data[i]  = '0;
      exp_be[i]    = '0;
    end
    mhead = 0;
  endtask

  task automatic set_commit(logic v);
    @(posedge CLK);
    commit_ena <= v;
  endtask

  task automatic wait_commits(int target);
    int cycles;
    cycles = 0;
    while (commit_count < target) begin
      @(posedge CLK);
      cycles++;
      if (cycles > 50) begin
        $display("Timed out with %0d of %0d commits seen", commit_count, target);
        $display("TEST FAILED");
        $finish;
      end
    end
  endtask

  task automatic finish_test(string name, int err_before);
    tests_run++;
    if (errors > err_before) begin
      tests_failed++;
      $display("test %0d %s: fail", tests_run, name);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
  endtask

  //==================================================
  // Tests
  //==================================================
  initial begin
    int err0;
    int base;
    lfsr = 16'd31719;
    errors = 0;
    commit_count = 0;
    tests_run = 0;
    tests_failed = 0;
    mhead = 0;
    last_be = '0;
    for (int i = 0; i < `VROB_ENTRIES; i++) begin
      exp_valid[i] = 1'b0;
      exp_vd[i]    = '0;
      exp_data[i]  = '0;
      exp_be[i]    = '0;
    end
    nRST       = 1'b0;
    flush      = 1'b0;
    alloc_ena  = 1'b0;
    lmul       = LMUL1;
    arith_wb   = '0;
    mul_wb     = '0;
    commit_ena = 1'b1;
    repeat (2) @(posedge CLK);
    nRST <= 1'b1;

    // Commit enabled so vreg_wen reflects the reset head entry
    err0 = errors;
    @(negedge CLK);
    check_val("commit.vreg_wen", 128'(commit.vreg_wen), 128'(0));
    check_val("full", 128'(full), 128'(0));
    check_val("cur_tail", 128'(cur_tail), 128'(0));
    finish_test("reset values", err0);

    err0 = errors;
    for (int i = 0; i < 16; i++) alloc(LMUL1, (i + 1) % 16);
    check_val("full", 128'(full), 128'(1));
    do_flush();
    alloc(LMUL2, 2);
    alloc(LMUL4, 6);
    alloc(LMUL8, 14);
    finish_test("allocation and full", err0);

    // Single SEW32 register held back until commit is enabled
    err0 = errors;
    set_commit(1'b0);
    do_flush();
    alloc(LMUL1, 1);
    send_wb(make_wb(0, 5, 0, 4, SEW32, 2'b11), '0);
    send_wb(make_wb(0, 5, 2, 4, SEW32, 2'b11), '0);
    repeat (6) begin
      @(negedge CLK);
      check_val("commit.vreg_wen", 128'(commit.vreg_wen), 128'(0));
    end
    base = commit_count;
    set_commit(1'b1);
    wait_commits(base + 1);
    check_val("commit.byte_ena", 128'(last_be), 128'(16'hffff));
    finish_test("sew32 lmul1 commit", err0);

    // Multiply port completes the second register first
    err0 = errors;
    do_flush();
    base = commit_count;
    alloc(LMUL2, 2);
    send_wb(make_wb(0, 8, 0, 16, SEW16, 2'b11), make_wb(0, 8, 8, 16, SEW16, 2'b11));
    send_wb(make_wb(0, 8, 2, 16, SEW16, 2'b11), make_wb(0, 8, 10, 16, SEW16, 2'b11));
    send_wb(make_wb(0, 8, 4, 16, SEW16, 2'b11), make_wb(0, 8, 12, 16, SEW16, 2'b11));
    send_wb('0, make_wb(0, 8, 14, 16, SEW16, 2'b11));
    repeat (4) @(posedge CLK);
    check_val("commit count", 128'(commit_count), 128'(base));
    send_wb(make_wb(0, 8, 6, 16, SEW16, 2'b11), '0);
    wait_commits(base + 2);
    alloc(LMUL2, 4);
    for (int k = 0; k < 8; k++) begin
      send_wb(make_wb(2, 16, 2 * k, 32, SEW8, 2'b11),
              make_wb(2, 16, 16 + 2 * k, 32, SEW8, 2'b11));
    end
    wait_commits(base + 4);
    finish_test("lmul2 crossing and order", err0);

    // vl of 6 ends the register early, wen bits trim the enables
    err0 = errors;
    do_flush();
    base = commit_count;
    alloc(LMUL1, 1);
    send_wb(make_wb(0, 3, 0, 6, SEW16, 2'b11), '0);
    send_wb(make_wb(0, 3, 2, 6, SEW16, 2'b10), '0);
    send_wb(make_wb(0, 3, 4, 6, SEW16, 2'b01), '0);
    wait_commits(base + 1);
    check_val("commit.byte_ena", 128'(last_be), 128'(16'h03cf));
    finish_test("short vl and wen", err0);

    err0 = errors;
    set_commit(1'b0);
    do_flush();
    alloc(LMUL4, 4);
    send_wb(make_wb(0, 4, 0, 16, SEW32, 2'b11), make_wb(0, 4, 4, 16, SEW32, 2'b11));
    send_wb(make_wb(0, 4, 2, 16, SEW32, 2'b11), make_wb(0, 4, 6, 16, SEW32, 2'b11));
    repeat (2) @(posedge CLK);
    base = commit_count;
    do_flush();
    set_commit(1'b1);
    repeat (6) @(posedge CLK);
    @(negedge CLK);
    check_val("commit count", 128'(commit_count), 128'(base));
    check_val("cur_tail", 128'(cur_tail), 128'(0));
    // Fill the buffer so the flush has to clear full
    alloc(LMUL8, 8);
    alloc(LMUL8, 0);
    check_val("full", 128'(full), 128'(1));
    do_flush();
    @(negedge CLK);
    check_val("full", 128'(full), 128'(0));
    finish_test("flush with pending entries", err0);

    $display("%0d tests, %0d failed, %0d errors, %0d commits",
             tests_run, tests_failed, errors, commit_count);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+common
common/vrob_pkg.sv
rob/wb_packer.sv
rob/rob_store.sv
src/vrob_top.sv
sim/tb_vrob.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_vrob
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   list these targets"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
